// File: sources.f
+incdir+dv
rtl/decode_pkg.sv
rtl/inst_capture.sv
rtl/ctrl_decode.sv
rtl/imm_gen.sv
rtl/decode_out_reg.sv
rtl/riscv_decode_top.sv
dv/decode_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module decode_tb -f sources.f

out=$(./obj_dir/Vdecode_tb 2>&1) || { echo "$out"; exit 1; }
echo "$out"

echo "$out" | grep -q "All tests passed"

// File: dv/decode_vectors.svh
// ##########################################################################
// vector entry type and the table of instructions with expected results
// ##########################################################################
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct {
    string       name;
    logic [31:0] word;
    dec_ctrl_t   ctrl;
    logic [31:0] imm;
} vec_t;

vec_t vectors[$];

// xfer packs the control transfer flags as {jal_en, jalr_en, branch_en}
function automatic void add_vec(string name, logic [31:0] word, logic [31:0] imm,
                                int wr, int rd, int rs1, int rs2, exu_op_e op,
                                exu_sel_e sel, lsu_op_e lsu, int xfer);
    vec_t      v;
    dec_ctrl_t c;
    c.rd_wr_en  = 1'(wr);
    c.rd_addr   = 5'(rd);
    c.rs1_addr  = 5'(rs1);
    c.rs2_addr  = 5'(rs2);
    c.exu_op    = op;
    c.exu_sel   = sel;
    c.lsu_op    = lsu;
    c.jal_en    = xfer[2];
    c.jalr_en   = xfer[1];
    c.branch_en = xfer[0];
    v.name      = name;
    v.word      = word;
    v.ctrl      = c;
    v.imm       = imm;
    vectors.push_back(v);
endfunction

// columns: name, word, imm, wr, rd, rs1, rs2, exu op, operand select, lsu op, xfer
function automatic void load_vectors();
    add_vec("lui", 'h800002b7, 'h80000000, 1, 5, 0, 0, EXU_ADD, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("auipc", 'h12345197, 'h12345000, 1, 3, 0, 0, EXU_ADD, SEL_PC_IMM, LSU_NONE, 0);
    add_vec("jal", 'hfffff0ef, 'hfffffffe, 1, 1, 0, 0, EXU_ADD, SEL_PC_4, LSU_NONE, 4);
    add_vec("jalr", 'h004100e7, 'h4, 1, 1, 2, 0, EXU_ADD, SEL_PC_4, LSU_NONE, 2);
    add_vec("addi", 'hfff58513, 'hffffffff, 1, 10, 11, 0, EXU_ADD, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("slti", 'h0055a513, 'h5, 1, 10, 11, 0, EXU_SLT, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("sltiu", 'h0055b513, 'h5, 1, 10, 11, 0, EXU_SLTU, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("xori", 'h0f05c513, 'hf0, 1, 10, 11, 0, EXU_XOR, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("ori", 'h1005e513, 'h100, 1, 10, 11, 0, EXU_OR, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("andi", 'h7ff5f513, 'h7ff, 1, 10, 11, 0, EXU_AND, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("slli", 'h00359513, 'h3, 1, 10, 11, 0, EXU_SLL, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("srli", 'h0075d513, 'h7, 1, 10, 11, 0, EXU_SRL, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("srai", 'h41f5d513, 'h1f, 1, 10, 11, 0, EXU_SRA, SEL_RS1_IMM, LSU_NONE, 0);
    add_vec("lb", 'hffc38303, 'hfffffffc, 1, 6, 7, 0, EXU_ADD, SEL_RS1_IMM, LSU_LB, 0);
    add_vec("lh", 'hffc39303, 'hfffffffc, 1, 6, 7, 0, EXU_ADD, SEL_RS1_IMM, LSU_LH, 0);
    add_vec("lw", 'h0083a303, 'h8, 1, 6, 7, 0, EXU_ADD, SEL_RS1_IMM, LSU_LW, 0);
    add_vec("lbu", 'h0003c303, 'h0, 1, 6, 7, 0, EXU_ADD, SEL_RS1_IMM, LSU_LBU, 0);
    add_vec("lhu", 'h0023d303, 'h2, 1, 6, 7, 0, EXU_ADD, SEL_RS1_IMM, LSU_LHU, 0);
    add_vec("sb", 'hfe940c23, 'hfffffff8, 0, 0, 8, 9, EXU_ADD, SEL_RS1_IMM, LSU_SB, 0);
    add_vec("sh", 'h00941623, 'hc, 0, 0, 8, 9, EXU_ADD, SEL_RS1_IMM, LSU_SH, 0);
    add_vec("sw", 'h7e942fa3, 'h7ff, 0, 0, 8, 9, EXU_ADD, SEL_RS1_IMM, LSU_SW, 0);
    add_vec("beq", 'hfed608e3, 'hfffffff0, 0, 0, 12, 13, EXU_BEQ, SEL_RS1_RS2, LSU_NONE, 1);
    add_vec("bne", 'h00d61463, 'h8, 0, 0, 12, 13, EXU_BNE, SEL_RS1_RS2, LSU_NONE, 1);
    add_vec("blt", 'h00d64463, 'h8, 0, 0, 12, 13, EXU_BLT, SEL_RS1_RS2, LSU_NONE, 1);
    add_vec("bge", 'h00d65463, 'h8, 0, 0, 12, 13, EXU_BGE, SEL_RS1_RS2, LSU_NONE, 1);
    add_vec("bltu", 'h00d66463, 'h8, 0, 0, 12, 13, EXU_BLTU, SEL_RS1_RS2, LSU_NONE, 1);
    add_vec("bgeu", 'h00d67463, 'h8, 0, 0, 12, 13, EXU_BGEU, SEL_RS1_RS2, LSU_NONE, 1);
    add_vec("add", 'h01078733, 'h0, 1, 14, 15, 16, EXU_ADD, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("sub", 'h41078733, 'h0, 1, 14, 15, 16, EXU_SUB, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("sll", 'h01079733, 'h0, 1, 14, 15, 16, EXU_SLL, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("slt", 'h0107a733, 'h0, 1, 14, 15, 16, EXU_SLT, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("sltu", 'h0107b733, 'h0, 1, 14, 15, 16, EXU_SLTU, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("xor", 'h0107c733, 'h0, 1, 14, 15, 16, EXU_XOR, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("srl", 'h0107d733, 'h0, 1, 14, 15, 16, EXU_SRL, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("sra", 'h4107d733, 'h0, 1, 14, 15, 16, EXU_SRA, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("or", 'h0107e733, 'h0, 1, 14, 15, 16, EXU_OR, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("and", 'h0107f733, 'h0, 1, 14, 15, 16, EXU_AND, SEL_RS1_RS2, LSU_NONE, 0);
    // encodings outside the kept set, all give the empty bundle
    add_vec("bad_opc", 'h0000007f, 'h0, 0, 0, 0, 0, EXU_ADD, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("ecall", 'h00000073, 'h0, 0, 0, 0, 0, EXU_ADD, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("csrrw", 'h300110f3, 'h0, 0, 0, 0, 0, EXU_ADD, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("mul", 'h03078733, 'h0, 0, 0, 0, 0, EXU_ADD, SEL_RS1_RS2, LSU_NONE, 0);
    add_vec("jalr_f3", 'h004110e7, 'h0, 0, 0, 0, 0, EXU_ADD, SEL_RS1_RS2, LSU_NONE, 0);
endfunction

`endif

// File: dv/decode_tb.sv
// ##########################################################################
// testbench for the decode stage: clock, reset, table driver, monitor
// ##########################################################################
`default_nettype none

module decode_tb
    import decode_pkg::*;
();

    localparam int XLEN  = 32;
    localparam int CLK_P = 8;

    logic              clk;
    logic              rst_n;
    logic              inst_valid;
    logic [INST_W-1:0] inst;
    logic              dec_valid;
    dec_ctrl_t         dec_out;
    logic [XLEN-1:0]   dec_imm;

    int seed;
    int cycle;
    int received;
    int pending[$];                     // cycle of each strobe not yet answered

    `include "decode_vectors.svh"

    riscv_decode_top #(.XLEN(XLEN)) dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec_out    (dec_out),
        .dec_imm    (dec_imm)
    );

    task automatic fail_run(string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_P / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // result of strobe at cycle c is seen at the falling edge of cycle c + 2
    always @(negedge clk) begin : monitor
        vec_t v;
        int   strobe_cycle;
        if (rst_n && dec_valid) begin
            if (pending.size() == 0) begin
                fail_run("dec_valid pulsed with no instruction pending");
            end else begin
                strobe_cycle = pending.pop_front();
                v            = vectors[received];
                check_value({v.name, " latency"}, 64'(strobe_cycle + 2), 64'(cycle));
                check_value({v.name, " ctrl"}, 64'(v.ctrl), 64'(dec_out));
                check_value({v.name, " imm"}, 64'(v.imm), 64'(dec_imm));
                received = received + 1;
            end
        end else if (rst_n && received > 0) begin
            v = vectors[received - 1];          // outputs keep the last result
            check_value({v.name, " hold ctrl"}, 64'(v.ctrl), 64'(dec_out));
            check_value({v.name, " hold imm"}, 64'(v.imm), 64'(dec_imm));
        end
    end

    initial begin : watchdog
        @(posedge rst_n);
        #((vectors.size() * 4 + 20) * CLK_P);
        fail_run("timeout, not every instruction came back");
    end

    initial begin : driver
        int gap;
        seed       = 32'hcbc4_dfde;
        cycle      = 0;
        received   = 0;
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        load_vectors();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value("reset dec_out", 64'h0, 64'(dec_out));
        check_value("reset dec_imm", 64'h0, 64'(dec_imm));
        foreach (vectors[i]) begin
            gap = $unsigned($random(seed)) % 3;   // 0 gives back to back strobes
            @(negedge clk);
            inst_valid = 1'b1;
            inst       = vectors[i].word;
            pending.push_back(cycle);
            repeat (gap) begin
                @(negedge clk);
                inst_valid = 1'b0;
                inst       = $random(seed);       // idle word, must be ignored
            end
        end
        @(negedge clk);
        inst_valid = 1'b0;
        inst       = $random(seed);
        while (received < vectors.size()) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);             // no extra pulses allowed
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/riscv_decode_top.sv
// ##########################################################################
// registered rv32i decode stage: capture, decode, immediate, output reg
// ##########################################################################
`default_nettype none

module riscv_decode_top
    import decode_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  logic [INST_W-1:0] inst,
    output logic              dec_valid,
    output dec_ctrl_t         dec_out,
    output logic [XLEN-1:0]   dec_imm
);

    logic              cap_valid;
    logic [INST_W-1:0] cap_inst;
    dec_ctrl_t         dec_ctrl;
    imm_fmt_e          imm_fmt;
    logic [XLEN-1:0]   imm;

    inst_capture u_inst_capture (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .cap_valid  (cap_valid),
        .cap_inst   (cap_inst)
    );

    ctrl_decode u_ctrl_decode (
        .cap_inst (cap_inst),
        .dec_ctrl (dec_ctrl),
        .imm_fmt  (imm_fmt)
    );

    imm_gen #(.XLEN(XLEN)) u_imm_gen (
        .cap_inst (cap_inst),
        .imm_fmt  (imm_fmt),
        .imm      (imm)
    );

    decode_out_reg #(.XLEN(XLEN)) u_decode_out_reg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cap_valid (cap_valid),
        .dec_ctrl  (dec_ctrl),
        .imm       (imm),
        .dec_valid (dec_valid),
        .dec_out   (dec_out),
        .dec_imm   (dec_imm)
    );

endmodule

`default_nettype wire

// File: rtl/decode_out_reg.sv
// ##########################################################################
// output register for the decoded bundle, immediate and dec_valid
// ##########################################################################
`default_nettype none

module decode_out_reg
    import decode_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cap_valid,
    input  dec_ctrl_t       dec_ctrl,
    input  logic [XLEN-1:0] imm,
    output logic            dec_valid,
    output dec_ctrl_t       dec_out,
    output logic [XLEN-1:0] dec_imm
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec_out   <= DEC_CTRL_NOP;
            dec_imm   <= '0;
        end else begin
            dec_valid <= cap_valid;
            if (cap_valid) begin
                dec_out <= dec_ctrl;    // held until the next instruction
                dec_imm <= imm;
            end
        end
    end

    // the decoder must never flag two kinds of control transfer at once
    one_xfer_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> $onehot0({dec_out.jal_en, dec_out.jalr_en, dec_out.branch_en})
    ) else $error("more than one of jal_en, jalr_en, branch_en is set");

endmodule

`default_nettype wire

// File: rtl/imm_gen.sv
// ##########################################################################
// immediate builder, gathers the fields per format and extends to XLEN
// ##########################################################################
`default_nettype none

module imm_gen
    import decode_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic [INST_W-1:0] cap_inst,
    input  imm_fmt_e          imm_fmt,
    output logic [XLEN-1:0]   imm
);

    logic signed [11:0] imm_i;
    logic signed [11:0] imm_s;
    logic signed [12:0] imm_b;
    logic signed [31:0] imm_u;
    logic signed [20:0] imm_j;
    logic        [4:0]  imm_sh;

    assign imm_i  = cap_inst[31:20];
    assign imm_s  = {cap_inst[31:25], cap_inst[11:7]};
    assign imm_b  = {cap_inst[31], cap_inst[7], cap_inst[30:25], cap_inst[11:8], 1'b0};
    assign imm_u  = {cap_inst[31:12], 12'b0};
    assign imm_j  = {cap_inst[31], cap_inst[19:12], cap_inst[20], cap_inst[30:21], 1'b0};
    assign imm_sh = cap_inst[24:20];

    // signed fields sign-extend on the size cast, shamt zero-extends
    always_comb begin
        case (imm_fmt)
            IMM_I:     imm = XLEN'(imm_i);
            IMM_S:     imm = XLEN'(imm_s);
            IMM_B:     imm = XLEN'(imm_b);
            IMM_U:     imm = XLEN'(imm_u);      // only widens when XLEN > 32
            IMM_J:     imm = XLEN'(imm_j);
            IMM_SHAMT: imm = XLEN'(imm_sh);
            default:   imm = '0;                // IMM_NONE
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/ctrl_decode.sv
// ##########################################################################
// opcode, func3 and func7 decode into the control bundle and imm format
// ##########################################################################
`default_nettype none

module ctrl_decode
    import decode_pkg::*;
(
    input  logic [INST_W-1:0] cap_inst,
    output dec_ctrl_t         dec_ctrl,
    output imm_fmt_e          imm_fmt
);

    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;   // sub and sra

    opcode_e    opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;

    logic       f7_base;
    logic       f7_alt;
    logic       reg_form;        // OP group, func7 is part of the encoding
    logic       plain_ok;        // func7 check for ops without an alt form
    exu_op_e    alu_op;
    logic       alu_ok;
    lsu_op_e    ld_op;
    lsu_op_e    st_op;
    exu_op_e    br_op;
    logic       br_ok;

    assign opcode   = opcode_e'(cap_inst[6:0]);
    assign func3    = cap_inst[14:12];
    assign func7    = cap_inst[31:25];
    assign rd       = cap_inst[11:7];
    assign rs1      = cap_inst[19:15];
    assign rs2      = cap_inst[24:20];

    assign f7_base  = (func7 == F7_BASE);
    assign f7_alt   = (func7 == F7_ALT);
    assign reg_form = (opcode == OPC_OP);
    assign plain_ok = !reg_form || f7_base;

    // alu operation shared by OP and OP-IMM
    always_comb begin
        alu_op = EXU_ADD;
        alu_ok = plain_ok;
        case (func3)
            3'b000: begin
                if (reg_form && f7_alt) begin
                    alu_op = EXU_SUB;
                    alu_ok = 1'b1;
                end
            end
            3'b001: begin
                alu_op = EXU_SLL;
                alu_ok = f7_base;       // slli carries func7 as well
            end
            3'b010: alu_op = EXU_SLT;
            3'b011: alu_op = EXU_SLTU;
            3'b100: alu_op = EXU_XOR;
            3'b101: begin
                alu_op = f7_alt ? EXU_SRA : EXU_SRL;
                alu_ok = f7_base || f7_alt;
            end
            3'b110: alu_op = EXU_OR;
            default: alu_op = EXU_AND;
        endcase
    end

    // func3 meaning for loads, stores and branches
    always_comb begin
        ld_op = LSU_NONE;
        st_op = LSU_NONE;
        br_op = EXU_BEQ;
        br_ok = 1'b1;
        case (func3)
            3'b000: begin
                ld_op = LSU_LB;
                st_op = LSU_SB;
            end
            3'b001: begin
                ld_op = LSU_LH;
                st_op = LSU_SH;
                br_op = EXU_BNE;
            end
            3'b010: begin
                ld_op = LSU_LW;
                st_op = LSU_SW;
                br_ok = 1'b0;
            end
            3'b011: br_ok = 1'b0;
            3'b100: begin
                ld_op = LSU_LBU;
                br_op = EXU_BLT;
            end
            3'b101: begin
                ld_op = LSU_LHU;
                br_op = EXU_BGE;
            end
            3'b110: br_op = EXU_BLTU;
            default: br_op = EXU_BGEU;
        endcase
    end

    always_comb begin
        dec_ctrl = DEC_CTRL_NOP;
        imm_fmt  = IMM_NONE;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                dec_ctrl.rd_wr_en = 1'b1;
                dec_ctrl.rd_addr  = rd;      // lui adds to x0
                dec_ctrl.exu_sel  = (opcode == OPC_LUI) ? SEL_RS1_IMM : SEL_PC_IMM;
                imm_fmt           = IMM_U;
            end
            OPC_JAL: begin
                dec_ctrl.rd_wr_en = 1'b1;
                dec_ctrl.rd_addr  = rd;
                dec_ctrl.exu_sel  = SEL_PC_4;    // link address
                dec_ctrl.jal_en   = 1'b1;
                imm_fmt           = IMM_J;
            end
            OPC_JALR: begin
                if (func3 == 3'b000) begin
                    dec_ctrl.rd_wr_en = 1'b1;
                    dec_ctrl.rd_addr  = rd;
                    dec_ctrl.rs1_addr = rs1;
                    dec_ctrl.exu_sel  = SEL_PC_4;
                    dec_ctrl.jalr_en  = 1'b1;
                    imm_fmt           = IMM_I;
                end
            end
            OPC_OP_IMM: begin
                if (alu_ok) begin
                    dec_ctrl.rd_wr_en = 1'b1;
                    dec_ctrl.rd_addr  = rd;
                    dec_ctrl.rs1_addr = rs1;
                    dec_ctrl.exu_op   = alu_op;
                    dec_ctrl.exu_sel  = SEL_RS1_IMM;
                    imm_fmt = (func3[1:0] == 2'b01) ? IMM_SHAMT : IMM_I;  // slli/srli/srai
                end
            end
            OPC_OP: begin
                if (alu_ok) begin
                    dec_ctrl.rd_wr_en = 1'b1;
                    dec_ctrl.rd_addr  = rd;
                    dec_ctrl.rs1_addr = rs1;
                    dec_ctrl.rs2_addr = rs2;
                    dec_ctrl.exu_op   = alu_op;
                end
            end
            OPC_LOAD: begin
                if (ld_op != LSU_NONE) begin
                    dec_ctrl.rd_wr_en = 1'b1;
                    dec_ctrl.rd_addr  = rd;
                    dec_ctrl.rs1_addr = rs1;
                    dec_ctrl.exu_sel  = SEL_RS1_IMM;   // address = rs1 + imm
                    dec_ctrl.lsu_op   = ld_op;
                    imm_fmt           = IMM_I;
                end
            end
            OPC_STORE: begin
                if (st_op != LSU_NONE) begin
                    dec_ctrl.rs1_addr = rs1;
                    dec_ctrl.rs2_addr = rs2;           // store data
                    dec_ctrl.exu_sel  = SEL_RS1_IMM;
                    dec_ctrl.lsu_op   = st_op;
                    imm_fmt           = IMM_S;
                end
            end
            OPC_BRANCH: begin
                if (br_ok) begin
                    dec_ctrl.rs1_addr  = rs1;
                    dec_ctrl.rs2_addr  = rs2;
                    dec_ctrl.exu_op    = br_op;
                    dec_ctrl.branch_en = 1'b1;
                    imm_fmt            = IMM_B;
                end
            end
            default: ;                                 // unknown, empty bundle
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/inst_capture.sv
// ##########################################################################
// input register for the instruction word and its strobe
// ##########################################################################
`default_nettype none

module inst_capture
    import decode_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  logic [INST_W-1:0] inst,
    output logic              cap_valid,
    output logic [INST_W-1:0] cap_inst
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= inst_valid;    // one cycle strobe, no hold
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid) begin
            cap_inst <= inst;           // word stays put between strobes
        end
    end

    // a strobed word must be fully defined before it enters the decoder
    inst_known_a : assert property (
        @(posedge clk) disable iff (!rst_n)
        inst_valid |-> !$isunknown(inst)
    ) else $error("inst has unknown bits while inst_valid is high");

endmodule

`default_nettype wire

// File: rtl/decode_pkg.sv
// ##########################################################################
// shared decode types: instruction width, opcode and operation enums,
// immediate format enum and the decoded control bundle
// ##########################################################################
`default_nettype none

package decode_pkg;

    localparam int INST_W = 32;           // rv32 instruction word

    // major opcodes handled by the decoder, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // execute unit operation, add must stay zero for the empty bundle
    typedef enum logic [3:0] {
        EXU_ADD  = 4'd0,
        EXU_SUB  = 4'd1,
        EXU_AND  = 4'd2,
        EXU_OR   = 4'd3,
        EXU_XOR  = 4'd4,
        EXU_SLL  = 4'd5,
        EXU_SRL  = 4'd6,
        EXU_SRA  = 4'd7,
        EXU_SLT  = 4'd8,
        EXU_SLTU = 4'd9,
        EXU_BEQ  = 4'd10,
        EXU_BNE  = 4'd11,
        EXU_BLT  = 4'd12,
        EXU_BGE  = 4'd13,
        EXU_BLTU = 4'd14,
        EXU_BGEU = 4'd15
    } exu_op_e;

    // operand pair fed to the execute unit
    typedef enum logic [1:0] {
        SEL_RS1_RS2 = 2'd0,
        SEL_RS1_IMM = 2'd1,
        SEL_PC_IMM  = 2'd2,
        SEL_PC_4    = 2'd3
    } exu_sel_e;

    // load/store unit operation
    typedef enum logic [3:0] {
        LSU_NONE = 4'd0,
        LSU_LB   = 4'd1,
        LSU_LH   = 4'd2,
        LSU_LW   = 4'd3,
        LSU_LBU  = 4'd4,
        LSU_LHU  = 4'd5,
        LSU_SB   = 4'd6,
        LSU_SH   = 4'd7,
        LSU_SW   = 4'd8
    } lsu_op_e;

    // immediate layout selected by the decoder
    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_S     = 3'd2,
        IMM_B     = 3'd3,
        IMM_U     = 3'd4,
        IMM_J     = 3'd5,
        IMM_SHAMT = 3'd6
    } imm_fmt_e;

    // decoded control bundle, first field is the msb
    typedef struct packed {
        logic     rd_wr_en;                // write back to rd
        logic [4:0] rd_addr;
        logic [4:0] rs1_addr;
        logic [4:0] rs2_addr;
        exu_op_e  exu_op;
        exu_sel_e exu_sel;
        lsu_op_e  lsu_op;
        logic     jal_en;
        logic     jalr_en;
        logic     branch_en;
    } dec_ctrl_t;

    // bundle for anything that is not recognized
    localparam dec_ctrl_t DEC_CTRL_NOP = '0;

endpackage

`default_nettype wire
